//--- clock_checker.sv
`timescale 1ns/10ps
`default_nettype none

module clock_checker (
	input  logic			clk,
	input  logic			rst_n,
	input  clock_pkg::seg_t		i_seg,
	input  clock_pkg::enb_t		i_seg_enb,
	input  logic			i_alarm,
	input  logic			i_req,		// compare at a settled frame
	input  logic			i_track,	// time of day is running
	input  logic	[5:0]		i_exp_hr,
	input  logic	[5:0]		i_exp_min,
	input  logic	[5:0]		i_exp_sec,
	input  logic			i_exp_alarm,
	output logic			o_done,
	output int			o_errors
);

	logic	[23:0]	cur;		// digit 5 on top
	logic	[23:0]	last;
	logic	[5:0]	vis;		// digit not blanked
	logic	[5:0]	last_vis;
	int		slot;
	int		prev_slot;
	int		age;		// frames since request
	int		ref_s;		// last shown time, seconds of day
	bit		started;
	bit		pending;
	bit		seeded;

	// segments a..g with a on top, active high
	function automatic logic [3:0] seg_digit(input clock_pkg::seg_t s);
		case (s)
			7'b111_1110: return 4'd0;
			7'b011_0000: return 4'd1;
			7'b110_1101: return 4'd2;
			7'b111_1001: return 4'd3;
			7'b011_0011: return 4'd4;
			7'b101_1011: return 4'd5;
			7'b101_1111: return 4'd6;
			7'b111_0000: return 4'd7;
			7'b111_1111: return 4'd8;
			7'b111_0011: return 4'd9;
			default:     return 4'hf;	// not a digit pattern
		endcase
	endfunction

	// ------------------------------
	// one full scan 0..5 is done
	// ------------------------------
	task automatic check_frame();
		int	hr;
		int	mn;
		int	sc;
		int	shown;
		hr = cur[23:20] * 10 + cur[19:16];
		mn = cur[15:12] * 10 + cur[11:8];
		sc = cur[7:4] * 10 + cur[3:0];
		shown = (hr * 60 + mn) * 60 + sc;
		age++;
		// settled means two equal frames with nothing blanked
		if (vis == 6'h3f && last_vis == 6'h3f && cur == last) begin
			if (i_track && seeded && shown != ref_s && shown != (ref_s + 1) % (24 * 3600)) begin
				$display("ERR o_seg: time %h:%h:%h followed by %h:%h:%h",
					6'(ref_s / 3600), 6'((ref_s / 60) % 60), 6'(ref_s % 60),
					6'(hr), 6'(mn), 6'(sc));
				o_errors++;
			end
			if (i_track) begin
				ref_s  = shown;
				seeded = 1'b1;
			end
			if (pending && age >= 3) begin	// both frames started after the request
				if (!i_track && (hr != i_exp_hr || mn != i_exp_min || sc != i_exp_sec)) begin
					$display("ERR o_seg: expected %h:%h:%h got %h:%h:%h",
						i_exp_hr, i_exp_min, i_exp_sec, 6'(hr), 6'(mn), 6'(sc));
					o_errors++;
				end
				if (i_alarm !== i_exp_alarm) begin
					$display("ERR o_alarm: expected %h got %h", i_exp_alarm, i_alarm);
					o_errors++;
				end
				pending = 1'b0;
				o_done <= 1'b1;
			end
		end
		last     = cur;
		last_vis = vis;
	endtask

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			slot     = -1;
			age      = 0;
			started  = 1'b0;
			pending  = 1'b0;
			seeded   = 1'b0;
			last_vis = '0;
			o_errors = 0;
			o_done  <= 1'b0;
		end else begin
			prev_slot = slot;
			slot = -1;
			for (int i = 0; i < clock_pkg::N_DIGITS; i++)
				if (!i_seg_enb[i])
					slot = i;
			if (i_req) begin
				pending = 1'b1;
				age     = 0;
				o_done <= 1'b0;
			end
			if (!i_track)
				seeded = 1'b0;	// reseed when tracking restarts
			if (slot == 0 && prev_slot != 0) begin
				if (started)
					check_frame();
				started = 1'b1;
			end
			if (slot >= 0) begin
				cur[slot*4 +: 4] = seg_digit(i_seg);
				vis[slot] = (i_seg != '0);
			end
		end
	end

endmodule

`default_nettype wire

//--- clock_pkg.sv
`default_nettype none

package clock_pkg;

	typedef enum logic [1:0] {
		MODE_CLOCK = 2'd0,
		MODE_SETUP = 2'd1,
		MODE_ALARM = 2'd2
	} mode_t;

	typedef enum logic [1:0] {
		POS_SEC = 2'd0,
		POS_MIN = 2'd1,
		POS_HR  = 2'd2
	} pos_t;	// field under edit

	typedef logic [5:0] field_t;	// 0..59 binary
	typedef logic [3:0] digit_t;
	typedef logic [6:0] seg_t;	// {a,b,c,d,e,f,g}, active high
	typedef logic [5:0] enb_t;	// one per digit, active low

	localparam int N_DIGITS = 6;
	localparam int N_KEYS   = 4;

	// button vector layout
	localparam int KEY_MODE  = 0;
	localparam int KEY_POS   = 1;
	localparam int KEY_INC   = 2;
	localparam int KEY_ALARM = 3;

	localparam field_t MIN_SEC_MAX = 6'd59;
	localparam field_t HR_MAX      = 6'd23;
	localparam seg_t   SEG_BLANK   = 7'b000_0000;

	function automatic seg_t digit_to_seg(input digit_t d);
		case (d)
			4'd0:    return 7'b111_1110;
			4'd1:    return 7'b011_0000;
			4'd2:    return 7'b110_1101;
			4'd3:    return 7'b111_1001;
			4'd4:    return 7'b011_0011;
			4'd5:    return 7'b101_1011;
			4'd6:    return 7'b101_1111;
			4'd7:    return 7'b111_0000;
			4'd8:    return 7'b111_1111;
			4'd9:    return 7'b111_0011;
			default: return SEG_BLANK;	// not a decimal digit
		endcase
	endfunction

endpackage

`default_nettype wire

//--- clock_sva.sv
`timescale 1ns/10ps
`default_nettype none

module clock_sva (
	input  logic			clk,
	input  logic			rst_n,
	input  clock_pkg::enb_t		i_seg_enb,
	input  logic			i_alarm,
	input  logic			i_alarm_en,
	input  clock_pkg::mode_t	i_mode
);

	int	n_fail = 0;	// assertion failures so far

	// one digit lit at a time once the scan runs
	a_one_digit: assert property (@(posedge clk) disable iff (!rst_n)
		i_seg_enb == '1 || $onehot(~i_seg_enb))
		else begin
			$error("more than one digit enable low");
			n_fail++;
		end

	a_scan_stays: assert property (@(posedge clk) disable iff (!rst_n)
		i_seg_enb != '1 |=> i_seg_enb != '1)
		else begin
			$error("digit scan stopped");
			n_fail++;
		end

	// registered output, so one cycle of lag after disable
	a_alarm_gated: assert property (@(posedge clk) disable iff (!rst_n)
		i_alarm |-> i_alarm_en || $past(i_alarm_en))
		else begin
			$error("alarm set while disabled");
			n_fail++;
		end

	a_mode_legal: assert property (@(posedge clk) disable iff (!rst_n)
		i_mode inside {clock_pkg::MODE_CLOCK, clock_pkg::MODE_SETUP, clock_pkg::MODE_ALARM})
		else begin
			$error("illegal mode encoding");
			n_fail++;
		end

endmodule

bind digital_clock_top clock_sva u_clock_sva (
	.clk		(clk),
	.rst_n		(rst_n),
	.i_seg_enb	(o_seg_enb),
	.i_alarm	(o_alarm),
	.i_alarm_en	(alarm_en),
	.i_mode		(mode)
);

`default_nettype wire

//--- digital_clock_top.sv
`timescale 1ns/10ps
`default_nettype none

module digital_clock_top #(
	parameter int TICK_DIV  = 50_000_000,	// 1 Hz at 50 MHz
	parameter int SCAN_DIV  = 50_000,
	parameter int BLINK_DIV = 12_500_000,
	parameter int DEB_DIV   = 500_000
) (
	input  logic				clk,
	input  logic				rst_n,
	input  logic	[clock_pkg::N_KEYS-1:0]	i_btn,
	output clock_pkg::seg_t			o_seg,
	output clock_pkg::enb_t			o_seg_enb,
	output logic				o_alarm
);

	logic			sec_tick;
	clock_pkg::mode_t	mode;
	clock_pkg::pos_t	pos;
	logic			alarm_en;
	logic			run;
	logic	[2:0]		tod_step;
	logic	[2:0]		alm_step;
	clock_pkg::field_t	tod_sec, tod_min, tod_hr;
	clock_pkg::field_t	alm_sec, alm_min, alm_hr;
	logic			alarm_hit;

	tick_gen #(.DIV(TICK_DIV)) u_sec_tick (
		.clk	(clk),
		.rst_n	(rst_n),
		.o_tick	(sec_tick)
	);

	mode_ctrl #(.DEB_DIV(DEB_DIV)) u_mode_ctrl (
		.clk		(clk),
		.rst_n		(rst_n),
		.i_btn		(i_btn),
		.i_sec_tick	(sec_tick),
		.o_mode		(mode),
		.o_pos		(pos),
		.o_alarm_en	(alarm_en),
		.o_run		(run),
		.o_tod_step	(tod_step),
		.o_alm_step	(alm_step)
	);

	time_counter #(.CARRY(1)) u_tod (
		.clk(clk), .rst_n(rst_n), .i_run(run), .i_step(tod_step),
		.o_sec(tod_sec), .o_min(tod_min), .o_hr(tod_hr)
	);

	time_counter #(.CARRY(0)) u_alm (	// run ignored inside
		.clk(clk), .rst_n(rst_n), .i_run(run), .i_step(alm_step),
		.o_sec(alm_sec), .o_min(alm_min), .o_hr(alm_hr)
	);

	display_mux #(
		.SCAN_DIV	(SCAN_DIV),
		.BLINK_DIV	(BLINK_DIV)
	) u_display_mux (
		.clk(clk), .rst_n(rst_n), .i_mode(mode), .i_pos(pos),
		.i_tod_sec(tod_sec), .i_tod_min(tod_min), .i_tod_hr(tod_hr),
		.i_alm_sec(alm_sec), .i_alm_min(alm_min), .i_alm_hr(alm_hr),
		.o_seg(o_seg), .o_seg_enb(o_seg_enb)
	);

	// alarm latches on match, held until disabled
	assign alarm_hit = (tod_sec == alm_sec) && (tod_min == alm_min) && (tod_hr == alm_hr);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			o_alarm <= 1'b0;
		else
			o_alarm <= alarm_en && (alarm_hit || o_alarm);
	end

endmodule

`default_nettype wire

//--- display_mux.sv
`timescale 1ns/10ps
`default_nettype none

module display_mux #(
	parameter int SCAN_DIV  = 50_000,
	parameter int BLINK_DIV = 12_500_000
) (
	input  logic			clk,
	input  logic			rst_n,
	input  clock_pkg::mode_t	i_mode,
	input  clock_pkg::pos_t		i_pos,
	input  clock_pkg::field_t	i_tod_sec,
	input  clock_pkg::field_t	i_tod_min,
	input  clock_pkg::field_t	i_tod_hr,
	input  clock_pkg::field_t	i_alm_sec,
	input  clock_pkg::field_t	i_alm_min,
	input  clock_pkg::field_t	i_alm_hr,
	output clock_pkg::seg_t		o_seg,
	output clock_pkg::enb_t		o_seg_enb
);

	localparam int IW   = $clog2(clock_pkg::N_DIGITS);
	localparam int LAST = clock_pkg::N_DIGITS - 1;

	logic			scan_tick;
	logic			blink_tick;
	logic			scan_vld;	// set by first scan tick
	logic	[IW-1:0]	scan_idx;
	logic			blink_ph;	// 0 = selected pair off
	clock_pkg::field_t	show_sec;
	clock_pkg::field_t	show_min;
	clock_pkg::field_t	show_hr;
	clock_pkg::digit_t	digit [clock_pkg::N_DIGITS];
	logic	[clock_pkg::N_DIGITS-1:0]	blank_mask;

	tick_gen #(
		.DIV	(SCAN_DIV)
	) u_scan_tick (
		.clk	(clk),
		.rst_n	(rst_n),
		.o_tick	(scan_tick)
	);

	tick_gen #(
		.DIV	(BLINK_DIV)
	) u_blink_tick (
		.clk	(clk),
		.rst_n	(rst_n),
		.o_tick	(blink_tick)
	);

	// ------------------------------
	// digit values
	// ------------------------------
	assign show_sec = (i_mode == clock_pkg::MODE_ALARM) ? i_alm_sec : i_tod_sec;
	assign show_min = (i_mode == clock_pkg::MODE_ALARM) ? i_alm_min : i_tod_min;
	assign show_hr  = (i_mode == clock_pkg::MODE_ALARM) ? i_alm_hr  : i_tod_hr;

	always_comb begin
		digit[0] = clock_pkg::digit_t'(show_sec % 6'd10);
		digit[1] = clock_pkg::digit_t'(show_sec / 6'd10);
		digit[2] = clock_pkg::digit_t'(show_min % 6'd10);
		digit[3] = clock_pkg::digit_t'(show_min / 6'd10);
		digit[4] = clock_pkg::digit_t'(show_hr % 6'd10);
		digit[5] = clock_pkg::digit_t'(show_hr / 6'd10);
	end

	// blinking only while editing
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			blink_ph <= 1'b0;
		else if (blink_tick)
			blink_ph <= ~blink_ph;
	end

	always_comb begin
		blank_mask = '0;
		if (i_mode != clock_pkg::MODE_CLOCK && !blink_ph) begin
			case (i_pos)
				clock_pkg::POS_SEC: blank_mask = 6'b00_0011;
				clock_pkg::POS_MIN: blank_mask = 6'b00_1100;
				clock_pkg::POS_HR:  blank_mask = 6'b11_0000;
				default:            blank_mask = '0;
			endcase
		end
	end

	// ------------------------------
	// scan
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			scan_vld <= 1'b0;
			scan_idx <= '0;
		end else if (scan_tick) begin
			scan_vld <= 1'b1;
			if (scan_vld)
				scan_idx <= (scan_idx == IW'(LAST)) ? '0 : scan_idx + IW'(1);
		end
	end

	assign o_seg_enb = scan_vld ? ~(clock_pkg::enb_t'(1) << scan_idx) : '1;
	assign o_seg     = blank_mask[scan_idx] ? clock_pkg::SEG_BLANK
		: clock_pkg::digit_to_seg(digit[scan_idx]);

endmodule

`default_nettype wire

//--- key_debounce.sv
`timescale 1ns/10ps
`default_nettype none

module key_debounce #(
	parameter int DEB_DIV = 500_000
) (
	input  logic				clk,
	input  logic				rst_n,
	input  logic	[clock_pkg::N_KEYS-1:0]	i_btn,
	output logic	[clock_pkg::N_KEYS-1:0]	o_press
);

	logic				smp_tick;
	logic	[clock_pkg::N_KEYS-1:0]	smp_new;	// latest sample
	logic	[clock_pkg::N_KEYS-1:0]	smp_old;	// one sample back

	tick_gen #(
		.DIV	(DEB_DIV)
	) u_smp_tick (
		.clk	(clk),
		.rst_n	(rst_n),
		.o_tick	(smp_tick)
	);

	// low, high, high over three samples gives one press
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			smp_new <= '0;
			smp_old <= '0;
			o_press <= '0;
		end else begin
			o_press <= '0;	// single clock pulse
			if (smp_tick) begin
				smp_new <= i_btn;
				smp_old <= smp_new;
				o_press <= i_btn & smp_new & ~smp_old;
			end
		end
	end

endmodule

`default_nettype wire

//--- mode_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module mode_ctrl #(
	parameter int DEB_DIV = 500_000
) (
	input  logic				clk,
	input  logic				rst_n,
	input  logic	[clock_pkg::N_KEYS-1:0]	i_btn,
	input  logic				i_sec_tick,
	output clock_pkg::mode_t		o_mode,
	output clock_pkg::pos_t			o_pos,
	output logic				o_alarm_en,
	output logic				o_run,
	output logic	[2:0]			o_tod_step,	// {hr, min, sec}
	output logic	[2:0]			o_alm_step
);

	logic	[clock_pkg::N_KEYS-1:0]	press;
	logic	[2:0]			pos_hot;

	key_debounce #(
		.DEB_DIV	(DEB_DIV)
	) u_key_debounce (
		.clk		(clk),
		.rst_n		(rst_n),
		.i_btn		(i_btn),
		.o_press	(press)
	);

	// ------------------------------
	// mode and position FSMs
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_mode <= clock_pkg::MODE_CLOCK;
		end else if (press[clock_pkg::KEY_MODE]) begin
			case (o_mode)
				clock_pkg::MODE_CLOCK: o_mode <= clock_pkg::MODE_SETUP;
				clock_pkg::MODE_SETUP: o_mode <= clock_pkg::MODE_ALARM;
				default:               o_mode <= clock_pkg::MODE_CLOCK;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_pos <= clock_pkg::POS_SEC;
		end else if (press[clock_pkg::KEY_POS]) begin
			case (o_pos)
				clock_pkg::POS_SEC: o_pos <= clock_pkg::POS_MIN;
				clock_pkg::POS_MIN: o_pos <= clock_pkg::POS_HR;
				default:            o_pos <= clock_pkg::POS_SEC;
			endcase
		end
	end

	// alarm enable flips in any mode
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			o_alarm_en <= 1'b0;
		else if (press[clock_pkg::KEY_ALARM])
			o_alarm_en <= ~o_alarm_en;
	end

	// ------------------------------
	// increment routing
	// ------------------------------
	always_comb begin
		case (o_pos)
			clock_pkg::POS_SEC: pos_hot = 3'b001;
			clock_pkg::POS_MIN: pos_hot = 3'b010;
			clock_pkg::POS_HR:  pos_hot = 3'b100;
			default:            pos_hot = 3'b000;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_tod_step <= '0;
			o_alm_step <= '0;
		end else begin
			o_tod_step <= '0;
			o_alm_step <= '0;
			if (press[clock_pkg::KEY_INC]) begin
				if (o_mode == clock_pkg::MODE_SETUP)
					o_tod_step <= pos_hot;
				else if (o_mode == clock_pkg::MODE_ALARM)
					o_alm_step <= pos_hot;
				// ignored in clock mode
			end
		end
	end

	assign o_run = i_sec_tick && (o_mode != clock_pkg::MODE_SETUP);	// frozen while setting

endmodule

`default_nettype wire

//--- sim.f
clock_pkg.sv
tick_gen.sv
key_debounce.sv
mode_ctrl.sv
time_counter.sv
display_mux.sv
digital_clock_top.sv
clock_sva.sv
clock_checker.sv
tb_digital_clock.sv

//--- tb_digital_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_digital_clock;

	localparam int TICK_DIV  = 200;
	localparam int SCAN_DIV  = 4;
	localparam int BLINK_DIV = 64;
	localparam int DEB_DIV   = 4;
	localparam int HOLD      = 16;			// cycles held, then released
	localparam int IDLE      = clock_pkg::N_KEYS;	// no button, wait one press slot
	localparam int N_ROWS    = 17;

	typedef struct packed {
		int	key;
		int	cnt;
		bit	track;	// time runs, follow it instead of fixed values
		int	hr;
		int	mn;
		int	sc;
		bit	alarm;
	} row_t;

	// key, presses, track, expected hh mm ss, expected alarm
	row_t tbl [N_ROWS] = '{
		'{IDLE,                 0,   0, 0,  0,  0,  0},	// out of reset
		'{clock_pkg::KEY_MODE,  1,   0, 0,  0,  0,  0},	// setup, time frozen
		'{clock_pkg::KEY_POS,   1,   0, 0,  0,  0,  0},
		'{clock_pkg::KEY_INC,   59,  0, 0,  59, 0,  0},
		'{clock_pkg::KEY_POS,   1,   0, 0,  59, 0,  0},
		'{clock_pkg::KEY_INC,   23,  0, 23, 59, 0,  0},
		'{clock_pkg::KEY_POS,   1,   0, 23, 59, 0,  0},
		'{clock_pkg::KEY_INC,   58,  0, 23, 59, 58, 0},
		'{clock_pkg::KEY_INC,   2,   0, 23, 59, 0,  0},	// seconds wrap, no carry
		'{clock_pkg::KEY_INC,   40,  0, 23, 59, 40, 0},
		'{IDLE,                 10,  0, 23, 59, 40, 0},	// still frozen
		'{clock_pkg::KEY_MODE,  1,   0, 0,  0,  0,  0},	// alarm mode shows alarm time
		'{clock_pkg::KEY_INC,   3,   0, 0,  0,  3,  0},
		'{clock_pkg::KEY_ALARM, 1,   0, 0,  0,  3,  0},
		'{clock_pkg::KEY_MODE,  1,   1, 0,  0,  0,  0},	// back to clock
		'{IDLE,                 150, 1, 0,  0,  0,  1},	// midnight, then alarm
		'{clock_pkg::KEY_ALARM, 1,   1, 0,  0,  0,  0}
	};

	logic				clk;
	logic				rst_n;
	logic	[clock_pkg::N_KEYS-1:0]	btn;
	clock_pkg::seg_t		seg;
	clock_pkg::enb_t		seg_enb;
	logic				alarm_out;
	logic				chk_req;
	logic				chk_track;
	logic				chk_done;
	logic	[5:0]			exp_hr;
	logic	[5:0]			exp_min;
	logic	[5:0]			exp_sec;
	logic				exp_alarm;
	int				chk_errors;
	int				sva_errors;
	int				cycles = 0;
	int				limit;

	digital_clock_top #(
		.TICK_DIV	(TICK_DIV),
		.SCAN_DIV	(SCAN_DIV),
		.BLINK_DIV	(BLINK_DIV),
		.DEB_DIV	(DEB_DIV)
	) i_digital_clock_top (
		.clk		(clk),
		.rst_n		(rst_n),
		.i_btn		(btn),
		.o_seg		(seg),
		.o_seg_enb	(seg_enb),
		.o_alarm	(alarm_out)
	);

	clock_checker u_clock_checker (
		.clk(clk), .rst_n(rst_n), .i_seg(seg), .i_seg_enb(seg_enb),
		.i_alarm(alarm_out), .i_req(chk_req), .i_track(chk_track),
		.i_exp_hr(exp_hr), .i_exp_min(exp_min), .i_exp_sec(exp_sec),
		.i_exp_alarm(exp_alarm), .o_done(chk_done), .o_errors(chk_errors)
	);

	always #50 clk = ~clk;

	// run limit from table length
	always @(posedge clk) begin
		cycles++;
		if (cycles >= limit) begin
			$display("timeout: no result after %0d cycles", cycles);
			$display("Some tests failed");
			$finish;
		end
	end

	task automatic press_key(input int key);
		if (key < clock_pkg::N_KEYS)
			btn[key] = 1'b1;
		repeat (HOLD) @(negedge clk);
		btn = '0;
		repeat (HOLD) @(negedge clk);
	endtask

	task automatic apply_row(input int r);
		exp_hr    = 6'(tbl[r].hr);
		exp_min   = 6'(tbl[r].mn);
		exp_sec   = 6'(tbl[r].sc);
		exp_alarm = tbl[r].alarm;
		chk_track = tbl[r].track && (tbl[r].key != clock_pkg::KEY_MODE);	// display switches
		repeat (tbl[r].cnt) press_key(tbl[r].key);
		chk_track = tbl[r].track;
		chk_req = 1'b1;
		@(negedge clk);
		chk_req = 1'b0;
		while (!chk_done)
			@(negedge clk);
	endtask

	initial begin
		clk       = 1'b0;
		rst_n     = 1'b0;
		btn       = '0;
		chk_req   = 1'b0;
		chk_track = 1'b0;
		exp_hr    = '0;
		exp_min   = '0;
		exp_sec   = '0;
		exp_alarm = 1'b0;
		limit     = 20 * TICK_DIV;
		foreach (tbl[r])
			limit += tbl[r].cnt * 40 + 3 * TICK_DIV;	// presses plus settle time
		repeat (10) @(negedge clk);
		rst_n = 1'b1;
		foreach (tbl[r])
			apply_row(r);
		sva_errors = i_digital_clock_top.u_clock_sva.n_fail;
		$display("errors: %0d compare, %0d assertion", chk_errors, sva_errors);
		if (chk_errors == 0 && sva_errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tick_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tick_gen #(
	parameter int DIV = 1000
) (
	input  logic	clk,
	input  logic	rst_n,
	output logic	o_tick
);

	localparam int CW = (DIV > 1) ? $clog2(DIV) : 1;

	logic	[CW-1:0]	cnt;

	// free running divider, one pulse per DIV clocks
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt    <= '0;
			o_tick <= 1'b0;
		end else if (cnt == CW'(DIV - 1)) begin
			cnt    <= '0;
			o_tick <= 1'b1;	// reload cycle
		end else begin
			cnt    <= cnt + CW'(1);
			o_tick <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- time_counter.sv
`timescale 1ns/10ps
`default_nettype none

module time_counter #(
	parameter int CARRY = 1
) (
	input  logic		clk,
	input  logic		rst_n,
	input  logic		i_run,
	input  logic	[2:0]	i_step,	// {hr, min, sec}
	output clock_pkg::field_t	o_sec,
	output clock_pkg::field_t	o_min,
	output clock_pkg::field_t	o_hr
);

	logic	run_en;
	logic	sec_max;
	logic	min_max;
	logic	sec_inc;
	logic	min_inc;
	logic	hr_inc;

	// +1 modulo lim+1
	function automatic clock_pkg::field_t wrap_inc(
		input clock_pkg::field_t val,
		input clock_pkg::field_t lim
	);
		return (val >= lim) ? '0 : val + 6'd1;
	endfunction

	// alarm copy never runs on its own
	assign run_en  = (CARRY != 0) && i_run;

	assign sec_max = (o_sec == clock_pkg::MIN_SEC_MAX);
	assign min_max = (o_min == clock_pkg::MIN_SEC_MAX);

	// carries only come from the running second, steps never carry
	assign sec_inc = run_en || i_step[0];
	assign min_inc = (run_en && sec_max) || i_step[1];
	assign hr_inc  = (run_en && sec_max && min_max) || i_step[2];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_sec <= '0;
			o_min <= '0;
			o_hr  <= '0;
		end else begin
			if (sec_inc)
				o_sec <= wrap_inc(o_sec, clock_pkg::MIN_SEC_MAX);
			if (min_inc)
				o_min <= wrap_inc(o_min, clock_pkg::MIN_SEC_MAX);
			if (hr_inc)
				o_hr <= wrap_inc(o_hr, clock_pkg::HR_MAX);	// 23 -> 0
		end
	end

endmodule

`default_nettype wire
